/* logic/mlf_pkg.sv */
package mlf_pkg;

  // ********************************************************************
  // lane numbering
  // ********************************************************************

  localparam int LANE_W    = 2;
  localparam int NUM_LANES = 4;

  // a lane number travels with every word on both sides of the crossing
  typedef logic [LANE_W-1:0] lane_t;

  // ********************************************************************
  // read side arbiter
  // ********************************************************************

  // scan for a lane with data, pulse its read enable, then hold the word
  // until the consumer takes it
  typedef enum logic [1:0] {
    ARB_SCAN = 2'd0,
    ARB_READ = 2'd1,
    ARB_HOLD = 2'd2
  } arb_state_t;

endpackage

/* logic/fifo_if.sv */
`timescale 1ns/1ps

// write port of one lane, in the wr_clk domain
interface fifo_wr_if #(
  parameter int DATA_WIDTH = 8
);

  logic                  en;    // write strobe, only while full is low
  logic [DATA_WIDTH-1:0] data;
  logic                  full;
  logic                  afull;

  modport driver (
    output en,
    output data,
    input  full,
    input  afull
  );

  modport lane (
    input  en,
    input  data,
    output full,
    output afull
  );

endinterface

// read port of one lane, in the rd_clk domain
interface fifo_rd_if #(
  parameter int DATA_WIDTH = 8
);

  logic                  en;
  logic [DATA_WIDTH-1:0] data;  // valid one rd_clk cycle after the read
  logic                  empty;
  logic                  aempty;

  modport lane (
    input  en,
    output data,
    output empty,
    output aempty
  );

  modport drain (
    output en,
    input  data,
    input  empty,
    input  aempty
  );

endinterface

/* logic/dualport_ram.sv */
`timescale 1ns/1ps

module dualport_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read data only moves on a read, so it holds between reads
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* logic/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo #(
  parameter int DATA_WIDTH  = 8,
  parameter int FIFO_DEPTH  = 16,
  parameter int FIFO_AFULL  = FIFO_DEPTH - 2,
  parameter int FIFO_AEMPTY = 2
) (
  input  logic    wr_clk,
  input  logic    wr_rst_n,
  input  logic    rd_clk,
  input  logic    rd_rst_n,
  fifo_wr_if.lane wr,
  fifo_rd_if.lane rd
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  localparam logic [ADDR_WIDTH:0] AFULL_LVL  = (ADDR_WIDTH + 1)'(FIFO_AFULL);
  localparam logic [ADDR_WIDTH:0] AEMPTY_LVL = (ADDR_WIDTH + 1)'(FIFO_AEMPTY);

  // full when the Gray pointers differ in exactly the two top bits
  localparam logic [ADDR_WIDTH:0] GRAY_WRAP = {2'b11, {(ADDR_WIDTH - 1){1'b0}}};

  function automatic logic [ADDR_WIDTH:0] gray2bin(input logic [ADDR_WIDTH:0] gray);
    logic [ADDR_WIDTH:0] bin;
    bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  logic                wr_vld;
  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_nxt;
  logic [ADDR_WIDTH:0] wr_gray;
  logic [ADDR_WIDTH:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_gray_ws1;
  logic [ADDR_WIDTH:0] rd_gray_ws2;
  logic [ADDR_WIDTH:0] rd_bin_ws;
  logic [ADDR_WIDTH:0] wr_used_nxt;

  logic                rd_vld;
  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_nxt;
  logic [ADDR_WIDTH:0] rd_gray;
  logic [ADDR_WIDTH:0] rd_gray_nxt;
  logic [ADDR_WIDTH:0] wr_gray_rs1;
  logic [ADDR_WIDTH:0] wr_gray_rs2;
  logic [ADDR_WIDTH:0] wr_bin_rs;
  logic [ADDR_WIDTH:0] rd_used_nxt;

  dualport_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) ram_i (
    .wr_clk  (wr_clk),
    .wr_en   (wr_vld),
    .wr_addr (wr_bin[ADDR_WIDTH-1:0]),
    .wr_data (wr.data),
    .rd_clk  (rd_clk),
    .rd_en   (rd_vld),
    .rd_addr (rd_bin[ADDR_WIDTH-1:0]),
    .rd_data (rd.data)
  );

  // ********************************************************************
  // write domain
  // ********************************************************************

  assign wr_vld      = wr.en && !wr.full;
  assign wr_bin_nxt  = wr_bin + {{ADDR_WIDTH{1'b0}}, wr_vld};
  assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);
  assign rd_bin_ws   = gray2bin(rd_gray_ws2);
  assign wr_used_nxt = wr_bin_nxt - rd_bin_ws;  // never low, the read pointer only lags

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin      <= '0;
      wr_gray     <= '0;
      rd_gray_ws1 <= '0;
      rd_gray_ws2 <= '0;
      wr.full     <= 1'b0;
      wr.afull    <= 1'b0;
    end else begin
      wr_bin      <= wr_bin_nxt;
      wr_gray     <= wr_gray_nxt;
      rd_gray_ws1 <= rd_gray;
      rd_gray_ws2 <= rd_gray_ws1;
      wr.full     <= (wr_gray_nxt == (rd_gray_ws2 ^ GRAY_WRAP));
      wr.afull    <= (wr_used_nxt >= AFULL_LVL);
    end
  end

  // ********************************************************************
  // read domain
  // ********************************************************************

  assign rd_vld      = rd.en && !rd.empty;
  assign rd_bin_nxt  = rd_bin + {{ADDR_WIDTH{1'b0}}, rd_vld};
  assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);
  assign wr_bin_rs   = gray2bin(wr_gray_rs2);
  assign rd_used_nxt = wr_bin_rs - rd_bin_nxt;

  // empty and aempty settle three rd_clk edges after the write pointer moves
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin      <= '0;
      rd_gray     <= '0;
      wr_gray_rs1 <= '0;
      wr_gray_rs2 <= '0;
      rd.empty    <= 1'b1;
      rd.aempty   <= 1'b1;
    end else begin
      rd_bin      <= rd_bin_nxt;
      rd_gray     <= rd_gray_nxt;
      wr_gray_rs1 <= wr_gray;
      wr_gray_rs2 <= wr_gray_rs1;
      rd.empty    <= (rd_gray_nxt == wr_gray_rs2);
      rd.aempty   <= (rd_used_nxt <= AEMPTY_LVL);
    end
  end

endmodule

/* logic/lane_dispatch.sv */
`timescale 1ns/1ps

module lane_dispatch import mlf_pkg::*; #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  in_valid,
  input  lane_t                 in_lane,
  input  logic [DATA_WIDTH-1:0] in_data,
  output logic                  in_ready,
  fifo_wr_if.driver             lanes [NUM_LANES]
);

  logic                  stg_valid;
  lane_t                 stg_lane;
  logic [DATA_WIDTH-1:0] stg_data;
  logic [NUM_LANES-1:0]  lane_full;
  logic                  stg_leave;
  logic                  accept;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign lane_full[i]  = lanes[i].full;
    assign lanes[i].en   = stg_valid && (stg_lane == lane_t'(i)) && !lanes[i].full;
    assign lanes[i].data = stg_data;
  end

  assign stg_leave = stg_valid && !lane_full[stg_lane];
  assign in_ready  = !stg_valid || !lane_full[stg_lane];  // a leaving word frees the stage
  assign accept    = in_valid && in_ready;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      stg_valid <= 1'b0;
    end else if (accept) begin
      stg_valid <= 1'b1;
    end else if (stg_leave) begin
      stg_valid <= 1'b0;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (accept) begin
      stg_lane <= in_lane;
      stg_data <= in_data;
    end
  end

endmodule

/* logic/lane_arbiter.sv */
`timescale 1ns/1ps

module lane_arbiter import mlf_pkg::*; #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  fifo_rd_if.drain              lanes [NUM_LANES],
  output logic                  out_valid,
  output lane_t                 out_lane,
  output logic [DATA_WIDTH-1:0] out_data,
  input  logic                  out_ready
);

  arb_state_t            state;
  lane_t                 rr_ptr;      // lane in service, then the last one served
  lane_t                 pick_lane;
  logic                  pick_valid;
  logic [NUM_LANES-1:0]  lane_empty;
  logic [DATA_WIDTH-1:0] lane_data [NUM_LANES];
  logic                  capture;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign lane_empty[i] = lanes[i].empty;
    assign lane_data[i]  = lanes[i].data;
    assign lanes[i].en   = (state == ARB_READ) && (rr_ptr == lane_t'(i));
  end

  // nearest non-empty lane after rr_ptr, rr_ptr itself comes last
  always_comb begin
    lane_t idx;
    pick_valid = 1'b0;
    pick_lane  = rr_ptr;
    for (int k = NUM_LANES; k > 0; k--) begin
      idx = rr_ptr + lane_t'(k);
      if (!lane_empty[idx]) begin
        pick_valid = 1'b1;
        pick_lane  = idx;
      end
    end
  end

  assign capture = (state == ARB_HOLD) && !out_valid;  // RAM output is valid here

  // ********************************************************************
  // control FSM
  // ********************************************************************

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state     <= ARB_SCAN;
      rr_ptr    <= lane_t'(NUM_LANES - 1);  // lane 0 goes first
      out_valid <= 1'b0;
    end else begin
      case (state)
        ARB_SCAN: if (pick_valid) begin
          rr_ptr <= pick_lane;
          state  <= ARB_READ;
        end
        ARB_READ: state <= ARB_HOLD;
        ARB_HOLD: if (capture) begin
          out_valid <= 1'b1;
        end else if (out_ready) begin
          out_valid <= 1'b0;
          state     <= ARB_SCAN;
        end
        default: state <= ARB_SCAN;
      endcase
    end
  end

  always_ff @(posedge rd_clk) begin
    if (capture) begin
      out_data <= lane_data[rr_ptr];
      out_lane <= rr_ptr;
    end
  end

endmodule

/* logic/multi_lane_fifo.sv */
`timescale 1ns/1ps

module multi_lane_fifo import mlf_pkg::*; #(
  parameter int DATA_WIDTH  = 8,
  parameter int FIFO_DEPTH  = 16,
  parameter int FIFO_AFULL  = FIFO_DEPTH - 2,
  parameter int FIFO_AEMPTY = 2
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  in_valid,
  input  lane_t                 in_lane,
  input  logic [DATA_WIDTH-1:0] in_data,
  output logic                  in_ready,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  output logic                  out_valid,
  input  logic                  out_ready,
  output lane_t                 out_lane,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic [NUM_LANES-1:0]  lane_afull,
  output logic [NUM_LANES-1:0]  lane_aempty
);

  fifo_wr_if #(.DATA_WIDTH(DATA_WIDTH)) wr_if [NUM_LANES] ();
  fifo_rd_if #(.DATA_WIDTH(DATA_WIDTH)) rd_if [NUM_LANES] ();

  lane_dispatch #(
    .DATA_WIDTH (DATA_WIDTH)
  ) dispatch_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .in_valid (in_valid),
    .in_lane  (in_lane),
    .in_data  (in_data),
    .in_ready (in_ready),
    .lanes    (wr_if)
  );

  // ********************************************************************
  // one asynchronous FIFO per lane
  // ********************************************************************

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    async_fifo #(
      .DATA_WIDTH  (DATA_WIDTH),
      .FIFO_DEPTH  (FIFO_DEPTH),
      .FIFO_AFULL  (FIFO_AFULL),
      .FIFO_AEMPTY (FIFO_AEMPTY)
    ) fifo_i (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .wr       (wr_if[i]),
      .rd       (rd_if[i])
    );

    assign lane_afull[i]  = wr_if[i].afull;   // wr_clk domain
    assign lane_aempty[i] = rd_if[i].aempty;  // rd_clk domain
  end

  lane_arbiter #(
    .DATA_WIDTH (DATA_WIDTH)
  ) arbiter_i (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .lanes     (rd_if),
    .out_valid (out_valid),
    .out_lane  (out_lane),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

endmodule

/* sim/multi_lane_fifo_props.sv */
`timescale 1ns/1ps

module multi_lane_fifo_props (
  input logic wr_clk,
  input logic wr_rst_n,
  input logic rd_clk,
  input logic rd_rst_n,
  input logic wr_en,
  input logic wr_full,
  input logic rd_en,
  input logic rd_empty
);

  int fail_cnt = 0;  // failed assertions of this lane

  // the dispatcher has to hold a staged word while its lane is full
  a_no_write_when_full: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) !(wr_en && wr_full)
  ) else begin
    $error("write enable raised while the lane is full");
    fail_cnt++;
  end

  a_not_full_and_empty: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n || !rd_rst_n) !(wr_full && rd_empty)
  ) else begin
    $error("lane reports full and empty at the same time");
    fail_cnt++;
  end

  a_no_read_when_empty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) !(rd_en && rd_empty)
  ) else begin
    $error("read enable raised while the lane is empty");
    fail_cnt++;
  end

endmodule

// one copy per lane inside every async_fifo of the generate loop
bind async_fifo multi_lane_fifo_props props_i (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .wr_en    (wr.en),
  .wr_full  (wr.full),
  .rd_en    (rd.en),
  .rd_empty (rd.empty)
);

/* sim/fifo_checker.sv */
`timescale 1ns/1ps

module fifo_checker import mlf_pkg::*; #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  in_valid,
  input  logic                  in_ready,
  input  lane_t                 in_lane,
  input  logic [DATA_WIDTH-1:0] in_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  out_valid,
  input  logic                  out_ready,
  input  lane_t                 out_lane,
  input  logic [DATA_WIDTH-1:0] out_data,
  input  logic [NUM_LANES-1:0]  lane_afull,
  input  logic [NUM_LANES-1:0]  lane_aempty,
  input  logic                  rr_en,
  output int                    err_cnt,
  output int                    pending
);

  logic [DATA_WIDTH-1:0] exp_q [NUM_LANES][$];  // accepted words per lane, oldest first
  int                    n_in = 0;
  int                    n_out = 0;
  lane_t                 last_lane;
  logic                  last_vld = 1'b0;

  initial err_cnt = 0;
  assign pending = n_in - n_out;

  // handshakes are sampled mid-cycle, where every signal is stable
  always @(negedge wr_clk) begin
    if (wr_rst_n && in_valid && in_ready) begin
      exp_q[in_lane].push_back(in_data);
      n_in++;
    end
  end

  always @(negedge rd_clk) begin
    logic [DATA_WIDTH-1:0] exp_data;
    lane_t                 exp_lane;
    if (!rr_en) last_vld = 1'b0;
    if (rd_rst_n && out_valid && out_ready) begin
      n_out++;
      if (exp_q[out_lane].size() == 0) begin
        $display("output word %h on lane %0d was never written", out_data, out_lane);
        err_cnt++;
      end else begin
        exp_data = exp_q[out_lane].pop_front();
        if (out_data !== exp_data) begin
          $display("** Error: out_data on lane %0d expected %h got %h",
                   out_lane, exp_data, out_data);
          err_cnt++;
        end
      end
      if (rr_en) begin
        exp_lane = lane_t'(last_lane + 1'b1);  // next lane after the one just served
        if (last_vld && out_lane !== exp_lane) begin
          $display("** Error: out_lane expected %h got %h", exp_lane, out_lane);
          err_cnt++;
        end
        last_lane = out_lane;
        last_vld  = 1'b1;
      end
    end
  end

  // ********************************************************************
  // checks started by the testbench in quiet windows
  // ********************************************************************

  task automatic check_flags(input logic [NUM_LANES-1:0] exp_afull,
                             input logic [NUM_LANES-1:0] exp_aempty);
    if (lane_afull !== exp_afull) begin
      $display("** Error: lane_afull expected %h got %h", exp_afull, lane_afull);
      err_cnt++;
    end
    if (lane_aempty !== exp_aempty) begin
      $display("** Error: lane_aempty expected %h got %h", exp_aempty, lane_aempty);
      err_cnt++;
    end
  endtask

  task automatic check_reset();
    if (in_ready !== 1'b1) begin
      $display("** Error: in_ready expected %h got %h", 1'b1, in_ready);
      err_cnt++;
    end
    if (out_valid !== 1'b0) begin
      $display("** Error: out_valid expected %h got %h", 1'b0, out_valid);
      err_cnt++;
    end
    check_flags('0, '1);
  endtask

  task automatic check_drained();
    for (int i = 0; i < NUM_LANES; i++) begin
      if (exp_q[i].size() != 0) begin
        $display("lane %0d still holds %0d words that never came out", i, exp_q[i].size());
        err_cnt++;
      end
    end
  endtask

endmodule

/* sim/tb_multi_lane_fifo.sv */
`timescale 1ns/1ps

module tb_multi_lane_fifo import mlf_pkg::*; ();

  localparam int DATA_WIDTH   = 8;
  localparam int FIFO_DEPTH   = 16;
  localparam int FIFO_AFULL   = FIFO_DEPTH - 2;
  localparam int FIFO_AEMPTY  = 2;
  localparam int STALL_WINDOW = 40;  // wr_clk cycles with in_ready low that count as a stall

  localparam int KIND_STREAM = 0;
  localparam int KIND_STALL  = 1;
  localparam int KIND_RR     = 2;
  localparam int ANY_LANE    = -1;
  localparam int NUM_PHASES  = 6;

  // probabilities are in 256ths
  typedef struct {
    int kind;
    int n_words;
    int lane;
    int p_valid;
    int p_ready;
  } phase_t;

  phase_t phases [NUM_PHASES] = '{
    '{KIND_STREAM, 40, 0, 256, 256},
    '{KIND_STREAM, 60, ANY_LANE, 192, 128},
    '{KIND_STREAM, 60, ANY_LANE, 64, 224},
    '{KIND_STALL, FIFO_DEPTH + 2, 2, 256, 0},
    '{KIND_RR, 32, ANY_LANE, 256, 256},
    '{KIND_STREAM, 80, ANY_LANE, 128, 64}
  };

  logic                  wr_clk = 1'b0;
  logic                  rd_clk = 1'b0;
  logic                  wr_rst_n;
  logic                  rd_rst_n;
  logic                  in_valid;
  lane_t                 in_lane;
  logic [DATA_WIDTH-1:0] in_data;
  logic                  in_ready;
  logic                  out_valid;
  logic                  out_ready;
  lane_t                 out_lane;
  logic [DATA_WIDTH-1:0] out_data;
  logic [NUM_LANES-1:0]  lane_afull;
  logic [NUM_LANES-1:0]  lane_aempty;
  logic                  rr_en;
  int                    chk_errs;
  int                    chk_pending;
  int                    prop_errs [NUM_LANES];
  int                    tb_errs = 0;
  int                    ready_pct = 0;
  int                    rd_cycles = 0;
  int                    timeout_limit = 1000000;
  logic [31:0]           lfsr_wr = 32'hf229_e5bd;
  logic [31:0]           lfsr_rd = 32'hf229_e5bd;

  always #20 wr_clk = ~wr_clk;
  always #28 rd_clk = ~rd_clk;  // unrelated to wr_clk

  multi_lane_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AFULL  (FIFO_AFULL),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) dut_i (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .in_valid    (in_valid),
    .in_lane     (in_lane),
    .in_data     (in_data),
    .in_ready    (in_ready),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_lane    (out_lane),
    .out_data    (out_data),
    .lane_afull  (lane_afull),
    .lane_aempty (lane_aempty)
  );

  fifo_checker #(.DATA_WIDTH(DATA_WIDTH)) checker_i (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_lane     (in_lane),
    .in_data     (in_data),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_lane    (out_lane),
    .out_data    (out_data),
    .lane_afull  (lane_afull),
    .lane_aempty (lane_aempty),
    .rr_en       (rr_en),
    .err_cnt     (chk_errs),
    .pending     (chk_pending)
  );

  // failed assertions of the bound property checker in each lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_props
    assign prop_errs[i] = dut_i.g_lane[i].fifo_i.props_i.fail_cnt;
  end

  // ********************************************************************
  // random numbers
  // ********************************************************************

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(ref logic [31:0] state, input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      val   = {val[30:0], state[0]};
    end
    return val;
  endfunction

  always @(posedge rd_clk) begin
    #2;
    out_ready <= (int'(take_bits(lfsr_rd, 8)) < ready_pct);
  end

  always @(posedge rd_clk) begin
    rd_cycles++;
    if (rd_cycles >= timeout_limit) begin
      $display("timeout after %0d rd_clk cycles, the output stream never finished", rd_cycles);
      $display("Errors found");
      $finish;
    end
  end

  // ********************************************************************
  // stimulus tasks
  // ********************************************************************

  task automatic next_wr_cycle();
    @(posedge wr_clk);
    #2;
  endtask

  task automatic send_word(input lane_t lane, input logic [DATA_WIDTH-1:0] data);
    logic taken;
    taken    = 1'b0;
    in_valid = 1'b1;
    in_lane  = lane;
    in_data  = data;
    while (!taken) begin
      #1;
      taken = in_ready;  // in_ready is stable between edges and the word goes on the next one
      next_wr_cycle();
    end
    in_valid = 1'b0;
  endtask

  task automatic settle();
    repeat (4) @(posedge rd_clk);  // two synchronizer flops plus the flag register
    repeat (4) @(posedge wr_clk);
    #2;
  endtask

  task automatic drain();
    ready_pct = 256;
    while (chk_pending != 0) @(posedge rd_clk);
    settle();
    checker_i.check_flags('0, '1);
  endtask

  task automatic stall_lane(input lane_t lane);
    int   accepted;
    int   low_run;
    logic taken;
    accepted = 0;
    low_run  = 0;
    in_valid = 1'b1;
    in_lane  = lane;
    in_data  = DATA_WIDTH'(take_bits(lfsr_wr, DATA_WIDTH));
    while (low_run < STALL_WINDOW) begin
      #1;
      taken   = in_ready;
      low_run = taken ? 0 : low_run + 1;
      if (taken) accepted++;
      next_wr_cycle();
      if (taken) in_data = DATA_WIDTH'(take_bits(lfsr_wr, DATA_WIDTH));
    end
    in_valid = 1'b0;
    // the lane itself, the staging register and the arbiter's output register
    if (accepted != FIFO_DEPTH + 2) begin
      $display("** Error: words accepted before stall expected %h got %h",
               FIFO_DEPTH + 2, accepted);
      tb_errs++;
    end
    settle();
    checker_i.check_flags(NUM_LANES'(1) << lane, ~(NUM_LANES'(1) << lane));
  endtask

  // ********************************************************************
  // phase loop
  // ********************************************************************

  initial begin
    lane_t lane;
    int    total;
    int    prop_total;
    total = 0;
    for (int p = 0; p < NUM_PHASES; p++) total += phases[p].n_words;
    timeout_limit = total * 20 + 2000;
    wr_rst_n  = 1'b0;
    rd_rst_n  = 1'b0;
    in_valid  = 1'b0;
    in_lane   = '0;
    in_data   = '0;
    out_ready = 1'b0;
    rr_en     = 1'b0;
    fork
      begin
        repeat (3) @(posedge wr_clk);
        #2;
        wr_rst_n = 1'b1;
      end
      begin
        repeat (3) @(posedge rd_clk);
        #2;
        rd_rst_n = 1'b1;
      end
    join
    next_wr_cycle();
    checker_i.check_reset();

    for (int p = 0; p < NUM_PHASES; p++) begin
      case (phases[p].kind)
        KIND_STALL: begin
          ready_pct = 0;
          repeat (2) @(posedge rd_clk);
          next_wr_cycle();
          stall_lane(lane_t'(phases[p].lane));
        end
        KIND_RR: begin
          ready_pct = 0;
          repeat (2) @(posedge rd_clk);
          next_wr_cycle();
          for (int w = 0; w < phases[p].n_words; w++) begin
            send_word(lane_t'(w % NUM_LANES), DATA_WIDTH'(take_bits(lfsr_wr, DATA_WIDTH)));
          end
          settle();
          rr_en = 1'b1;
        end
        default: begin
          ready_pct = phases[p].p_ready;
          for (int w = 0; w < phases[p].n_words; w++) begin
            while (int'(take_bits(lfsr_wr, 8)) >= phases[p].p_valid) next_wr_cycle();
            if (phases[p].lane == ANY_LANE) lane = lane_t'(take_bits(lfsr_wr, LANE_W));
            else lane = lane_t'(phases[p].lane);
            send_word(lane, DATA_WIDTH'(take_bits(lfsr_wr, DATA_WIDTH)));
          end
        end
      endcase
      drain();
      rr_en = 1'b0;
    end

    checker_i.check_drained();
    prop_total = 0;
    for (int i = 0; i < NUM_LANES; i++) prop_total += prop_errs[i];
    $display("checker errors: %0d, testbench errors: %0d, assertion errors: %0d",
             chk_errs, tb_errs, prop_total);
    if (chk_errs == 0 && tb_errs == 0 && prop_total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* files.f */
logic/mlf_pkg.sv
logic/fifo_if.sv
logic/dualport_ram.sv
logic/async_fifo.sv
logic/lane_dispatch.sv
logic/lane_arbiter.sv
logic/multi_lane_fifo.sv
sim/multi_lane_fifo_props.sv
sim/fifo_checker.sv
sim/tb_multi_lane_fifo.sv

/* Bender.yml */
package:
  name: multi_lane_fifo

sources:
  - logic/mlf_pkg.sv
  - logic/fifo_if.sv
  - logic/dualport_ram.sv
  - logic/async_fifo.sv
  - logic/lane_dispatch.sv
  - logic/lane_arbiter.sv
  - logic/multi_lane_fifo.sv
  - target: simulation
    files:
      - sim/multi_lane_fifo_props.sv
      - sim/fifo_checker.sv
      - sim/tb_multi_lane_fifo.sv
